//--- cache_sim_settings.svh
`ifndef CACHE_SIM_SETTINGS_SVH
`define CACHE_SIM_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Access format
//////////////////////////////////////////////////////////////////////

// Byte address of one access
`define CACHE_ADDR_W 48

// Offset bits inside a block, 64-byte blocks
`define CACHE_BLOCK_BITS 6

//////////////////////////////////////////////////////////////////////
// Level geometry
//////////////////////////////////////////////////////////////////////

// L1 is 2 KiB, 8 ways of 4 sets
`define CACHE_L1_WAYS 8
`define CACHE_L1_SET_BITS 2

// L2 is 16 KiB, 4 ways of 64 sets
`define CACHE_L2_WAYS 4
`define CACHE_L2_SET_BITS 6

//////////////////////////////////////////////////////////////////////
// Statistics
//////////////////////////////////////////////////////////////////////

// Width of every statistics counter, wraps at the top
`define CACHE_CNT_W 12

`endif

//--- cache_sim_pkg.sv
`include "cache_sim_settings.svh"

package cache_sim_pkg;

  // Access opcode
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // Replacement order inside a set
  typedef enum logic {
    REPL_FIFO = 1'b0,
    REPL_LRU  = 1'b1
  } repl_e;

  // Write counting rule toward L2
  typedef enum logic {
    WP_THROUGH = 1'b0,
    WP_BACK    = 1'b1
  } wpol_e;

  // Controller sequence, one access at a time
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_LOOKUP = 2'd1,
    ST_UPDATE = 2'd2,
    ST_DONE   = 2'd3
  } ctrl_state_e;

  // Unsigned statistics value
  typedef logic [`CACHE_CNT_W-1:0] count_t;

endpackage

//--- tag_store.sv
`timescale 1ns/100ps

module tag_store #(
  parameter int WAYS     = 8,
  parameter int SET_BITS = 2,
  parameter int TAG_W    = 40
) (
  input  logic clk,
  input  logic reset,
  input  logic [SET_BITS-1:0] set_idx,
  input  logic [TAG_W-1:0] tag,
  input  logic fill,
  input  logic promote,
  output logic hit
);

  localparam int SETS  = 1 << SET_BITS;
  localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1;

  // Position 0 is newest or most recently used
  logic [TAG_W-1:0] tags [SETS][WAYS];
  logic [WAYS-1:0] valid [SETS];

  logic [WAYS-1:0] match;
  logic [WAY_W-1:0] hit_way;
  // Per-position load enable, position w takes w-1
  logic [WAYS-1:0] shift;

  //////////////////////////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////////////////////////

  // All ways of the selected set compared at once
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      match[w] = valid[set_idx][w] && (tags[set_idx][w] == tag);
    end
  end

  assign hit = |match;

  // Position of the matching way
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (match[w]) begin
        hit_way = WAY_W'(w);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reordering
  //////////////////////////////////////////////////////////////////////

  // Fill moves every entry back, last one falls off
  // Promote only moves the entries ahead of the hit way
  always_comb begin
    shift[0] = fill || promote;
    for (int w = 1; w < WAYS; w++) begin
      shift[w] = fill || (promote && (WAY_W'(w) <= hit_way));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      // Every way starts invalid
      for (int s = 0; s < SETS; s++) begin
        valid[s] <= '0;
      end
    end else begin
      for (int w = WAYS - 1; w > 0; w--) begin
        if (shift[w]) begin
          valid[set_idx][w] <= valid[set_idx][w-1];
        end
      end
      if (shift[0]) begin
        valid[set_idx][0] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int w = WAYS - 1; w > 0; w--) begin
      if (shift[w]) begin
        tags[set_idx][w] <= tags[set_idx][w-1];
      end
    end
    // Front always gets the access tag
    if (shift[0]) begin
      tags[set_idx][0] <= tag;
    end
  end

  // No duplicate tags in a set when reordering
  a_single_match: assert property (@(posedge clk) disable iff (reset)
    (fill || promote) |-> $onehot0(match));

  // Controller promotes only what the lookup found
  a_promote_on_hit: assert property (@(posedge clk) disable iff (reset)
    promote |-> hit);

endmodule

//--- stat_counters.sv
`timescale 1ns/100ps

module stat_counters
  import cache_sim_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic inc_l1_read,
  input  logic inc_l1_hit,
  input  logic inc_l1_miss,
  input  logic inc_l1_write,
  input  logic inc_l2_read,
  input  logic inc_l2_hit,
  input  logic inc_l2_miss,
  input  logic inc_l2_write,
  output count_t l1_reads,
  output count_t l1_hits,
  output count_t l1_misses,
  output count_t l1_writes,
  output count_t l2_reads,
  output count_t l2_hits,
  output count_t l2_misses,
  output count_t l2_writes
);

  localparam int N_CNT = 8;

  // Strobes gathered, L1 in the low half
  logic [N_CNT-1:0] inc;
  count_t cnt [N_CNT];

  assign inc = {inc_l2_write, inc_l2_miss, inc_l2_hit, inc_l2_read,
                inc_l1_write, inc_l1_miss, inc_l1_hit, inc_l1_read};

  // Each counter wraps at its width
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < N_CNT; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N_CNT; i++) begin
        if (inc[i]) begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  assign l1_reads  = cnt[0];
  assign l1_hits   = cnt[1];
  assign l1_misses = cnt[2];
  assign l1_writes = cnt[3];
  assign l2_reads  = cnt[4];
  assign l2_hits   = cnt[5];
  assign l2_misses = cnt[6];
  assign l2_writes = cnt[7];

endmodule

//--- cache_ctrl.sv
`timescale 1ns/100ps
`include "cache_sim_settings.svh"

module cache_ctrl
  import cache_sim_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic [`CACHE_ADDR_W-1:0] addr,
  input  op_e op,
  input  repl_e replace_policy,
  input  wpol_e write_policy,
  input  logic l1_hit,
  input  logic l2_hit,
  output logic busy,
  output logic done,
  output logic [`CACHE_L1_SET_BITS-1:0] l1_set,
  output logic [`CACHE_ADDR_W-`CACHE_BLOCK_BITS-`CACHE_L1_SET_BITS-1:0] l1_tag,
  output logic [`CACHE_L2_SET_BITS-1:0] l2_set,
  output logic [`CACHE_ADDR_W-`CACHE_BLOCK_BITS-`CACHE_L2_SET_BITS-1:0] l2_tag,
  output logic l1_fill,
  output logic l1_promote,
  output logic l2_fill,
  output logic l2_promote,
  output logic inc_l1_read,
  output logic inc_l1_hit,
  output logic inc_l1_miss,
  output logic inc_l1_write,
  output logic inc_l2_read,
  output logic inc_l2_hit,
  output logic inc_l2_miss,
  output logic inc_l2_write
);

  // Block number width, address without the offset
  localparam int BLK_W    = `CACHE_ADDR_W - `CACHE_BLOCK_BITS;
  localparam int L1_TAG_W = BLK_W - `CACHE_L1_SET_BITS;
  localparam int L2_TAG_W = BLK_W - `CACHE_L2_SET_BITS;

  ctrl_state_e state;
  ctrl_state_e state_nxt;

  // Latched request
  logic [`CACHE_ADDR_W-1:0] addr_q;
  op_e   op_q;
  repl_e repl_q;
  wpol_e wpol_q;

  // Lookup results, held for the update cycle
  logic l1_hit_q;
  logic l2_hit_q;

  logic [BLK_W-1:0] block;
  logic accept;
  logic in_update;
  logic lru;
  logic l1_miss;
  logic is_write;

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  // New access only from idle
  assign accept = (state == ST_IDLE) && start;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:   if (start) state_nxt = ST_LOOKUP;
      ST_LOOKUP: state_nxt = ST_UPDATE;
      ST_UPDATE: state_nxt = ST_DONE;
      ST_DONE:   state_nxt = ST_IDLE;
      default:   state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Request and both policies held for the whole access
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= addr;
      op_q   <= op;
      repl_q <= replace_policy;
      wpol_q <= write_policy;
    end
  end

  // Tag stores compare during lookup
  always_ff @(posedge clk) begin
    if (state == ST_LOOKUP) begin
      l1_hit_q <= l1_hit;
      l2_hit_q <= l2_hit;
    end
  end

  assign busy = (state != ST_IDLE);
  assign done = (state == ST_DONE);

  //////////////////////////////////////////////////////////////////////
  // Address split
  //////////////////////////////////////////////////////////////////////

  assign block  = addr_q[`CACHE_ADDR_W-1:`CACHE_BLOCK_BITS];
  // Low block bits pick the set, the rest is the tag
  assign l1_set = block[`CACHE_L1_SET_BITS-1:0];
  assign l1_tag = block[BLK_W-1:BLK_W-L1_TAG_W];
  assign l2_set = block[`CACHE_L2_SET_BITS-1:0];
  assign l2_tag = block[BLK_W-1:BLK_W-L2_TAG_W];

  //////////////////////////////////////////////////////////////////////
  // Update decisions
  //////////////////////////////////////////////////////////////////////

  assign in_update = (state == ST_UPDATE);
  assign lru       = (repl_q == REPL_LRU);
  assign l1_miss   = !l1_hit_q;
  assign is_write  = (op_q == OP_WRITE);

  // L2 only acts behind an L1 miss
  assign l1_fill    = in_update && l1_miss;
  assign l1_promote = in_update && l1_hit_q && lru;
  assign l2_fill    = in_update && l1_miss && !l2_hit_q;
  assign l2_promote = in_update && l1_miss && l2_hit_q && lru;

  // Counter strobes
  assign inc_l1_read  = in_update && !is_write;
  assign inc_l1_write = in_update && is_write;
  assign inc_l1_hit   = in_update && l1_hit_q;
  assign inc_l1_miss  = in_update && l1_miss;
  assign inc_l2_read  = in_update && l1_miss;
  assign inc_l2_hit   = in_update && l1_miss && l2_hit_q;
  assign inc_l2_miss  = in_update && l1_miss && !l2_hit_q;
  // Write-back reaches L2 only when L1 missed
  assign inc_l2_write = in_update && is_write && ((wpol_q == WP_THROUGH) || l1_miss);

  // Single-cycle done, right after the update cycle
  a_done_after_update: assert property (@(posedge clk) disable iff (reset)
    done |-> ($past(state) == ST_UPDATE) ##1 !done);

  // Miss fill and hit promote are exclusive in L1
  a_l1_fill_xor_promote: assert property (@(posedge clk) disable iff (reset)
    !(l1_fill && l1_promote));

endmodule

//--- cache_sim_top.sv
`timescale 1ns/100ps
`include "cache_sim_settings.svh"

module cache_sim_top
  import cache_sim_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic [`CACHE_ADDR_W-1:0] addr,
  input  op_e op,
  input  repl_e replace_policy,
  input  wpol_e write_policy,
  output logic busy,
  output logic done,
  output count_t l1_reads,
  output count_t l1_hits,
  output count_t l1_misses,
  output count_t l1_writes,
  output count_t l2_reads,
  output count_t l2_hits,
  output count_t l2_misses,
  output count_t l2_writes
);

  // Tag widths per level
  localparam int L1_TAG_W = `CACHE_ADDR_W - `CACHE_BLOCK_BITS - `CACHE_L1_SET_BITS;
  localparam int L2_TAG_W = `CACHE_ADDR_W - `CACHE_BLOCK_BITS - `CACHE_L2_SET_BITS;

  // Controller to tag stores
  logic [`CACHE_L1_SET_BITS-1:0] l1_set;
  logic [L1_TAG_W-1:0] l1_tag;
  logic [`CACHE_L2_SET_BITS-1:0] l2_set;
  logic [L2_TAG_W-1:0] l2_tag;
  logic l1_fill;
  logic l1_promote;
  logic l2_fill;
  logic l2_promote;
  logic l1_hit;
  logic l2_hit;

  // Controller to counters
  logic inc_l1_read;
  logic inc_l1_hit;
  logic inc_l1_miss;
  logic inc_l1_write;
  logic inc_l2_read;
  logic inc_l2_hit;
  logic inc_l2_miss;
  logic inc_l2_write;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  cache_ctrl i_cache_ctrl (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .addr           (addr),
    .op             (op),
    .replace_policy (replace_policy),
    .write_policy   (write_policy),
    .l1_hit         (l1_hit),
    .l2_hit         (l2_hit),
    .busy           (busy),
    .done           (done),
    .l1_set         (l1_set),
    .l1_tag         (l1_tag),
    .l2_set         (l2_set),
    .l2_tag         (l2_tag),
    .l1_fill        (l1_fill),
    .l1_promote     (l1_promote),
    .l2_fill        (l2_fill),
    .l2_promote     (l2_promote),
    .inc_l1_read    (inc_l1_read),
    .inc_l1_hit     (inc_l1_hit),
    .inc_l1_miss    (inc_l1_miss),
    .inc_l1_write   (inc_l1_write),
    .inc_l2_read    (inc_l2_read),
    .inc_l2_hit     (inc_l2_hit),
    .inc_l2_miss    (inc_l2_miss),
    .inc_l2_write   (inc_l2_write)
  );

  //////////////////////////////////////////////////////////////////////
  // Tag stores, one per level
  //////////////////////////////////////////////////////////////////////

  tag_store #(
    .WAYS     (`CACHE_L1_WAYS),
    .SET_BITS (`CACHE_L1_SET_BITS),
    .TAG_W    (L1_TAG_W)
  ) l1_tags (
    .clk     (clk),
    .reset   (reset),
    .set_idx (l1_set),
    .tag     (l1_tag),
    .fill    (l1_fill),
    .promote (l1_promote),
    .hit     (l1_hit)
  );

  tag_store #(
    .WAYS     (`CACHE_L2_WAYS),
    .SET_BITS (`CACHE_L2_SET_BITS),
    .TAG_W    (L2_TAG_W)
  ) l2_tags (
    .clk     (clk),
    .reset   (reset),
    .set_idx (l2_set),
    .tag     (l2_tag),
    .fill    (l2_fill),
    .promote (l2_promote),
    .hit     (l2_hit)
  );

  //////////////////////////////////////////////////////////////////////
  // Statistics
  //////////////////////////////////////////////////////////////////////

  stat_counters i_stat_counters (
    .clk          (clk),
    .reset        (reset),
    .inc_l1_read  (inc_l1_read),
    .inc_l1_hit   (inc_l1_hit),
    .inc_l1_miss  (inc_l1_miss),
    .inc_l1_write (inc_l1_write),
    .inc_l2_read  (inc_l2_read),
    .inc_l2_hit   (inc_l2_hit),
    .inc_l2_miss  (inc_l2_miss),
    .inc_l2_write (inc_l2_write),
    .l1_reads     (l1_reads),
    .l1_hits      (l1_hits),
    .l1_misses    (l1_misses),
    .l1_writes    (l1_writes),
    .l2_reads     (l2_reads),
    .l2_hits      (l2_hits),
    .l2_misses    (l2_misses),
    .l2_writes    (l2_writes)
  );

endmodule

//--- cache_checker.sv
`timescale 1ns/100ps
`include "cache_sim_settings.svh"

module cache_checker
  import cache_sim_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic [`CACHE_ADDR_W-1:0] addr,
  input  op_e op,
  input  repl_e replace_policy,
  input  wpol_e write_policy,
  input  logic busy,
  input  logic done,
  input  count_t l1_reads,
  input  count_t l1_hits,
  input  count_t l1_misses,
  input  count_t l1_writes,
  input  count_t l2_reads,
  input  count_t l2_hits,
  input  count_t l2_misses,
  input  count_t l2_writes,
  output int errors,
  output int checked
);

  localparam int N_CNT         = 8;
  localparam int MAX_SETS      = 1 << `CACHE_L2_SET_BITS;
  localparam int MAX_WAYS      = `CACHE_L1_WAYS;
  localparam int DONE_LATENCY  = 3;
  localparam int DONE_TIMEOUT  = 20;
  localparam int RESET_TIMEOUT = 100;

  // Reference tag lists, index 0 is L1, position 0 is newest
  logic [`CACHE_ADDR_W-1:0] m_tag [2][MAX_SETS][MAX_WAYS];
  logic m_valid [2][MAX_SETS][MAX_WAYS];

  // Predicted and observed counters, same order as the DUT ports
  count_t expected [N_CNT];
  count_t actual [N_CNT];
  string cnt_name [N_CNT] = '{"l1_reads", "l1_hits", "l1_misses", "l1_writes",
                              "l2_reads", "l2_hits", "l2_misses", "l2_writes"};

  assign actual[0] = l1_reads;
  assign actual[1] = l1_hits;
  assign actual[2] = l1_misses;
  assign actual[3] = l1_writes;
  assign actual[4] = l2_reads;
  assign actual[5] = l2_hits;
  assign actual[6] = l2_misses;
  assign actual[7] = l2_writes;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic int ways_of(input int lvl);
    return (lvl == 0) ? `CACHE_L1_WAYS : `CACHE_L2_WAYS;
  endfunction

  function automatic int set_bits_of(input int lvl);
    return (lvl == 0) ? `CACHE_L1_SET_BITS : `CACHE_L2_SET_BITS;
  endfunction

  // Position of a valid matching tag, -1 on a miss
  function automatic int find_way(input int lvl, input int set,
                                  input logic [`CACHE_ADDR_W-1:0] tag);
    for (int w = 0; w < ways_of(lvl); w++) begin
      if (m_valid[lvl][set][w] && (m_tag[lvl][set][w] == tag)) begin
        return w;
      end
    end
    return -1;
  endfunction

  // Entries ahead of pos move back one, tag lands at the front
  // A fill is the same move from the last position
  task automatic move_to_front(input int lvl, input int set, input int pos,
                               input logic [`CACHE_ADDR_W-1:0] tag);
    for (int w = pos; w > 0; w--) begin
      m_tag[lvl][set][w]   = m_tag[lvl][set][w-1];
      m_valid[lvl][set][w] = m_valid[lvl][set][w-1];
    end
    m_tag[lvl][set][0]   = tag;
    m_valid[lvl][set][0] = 1'b1;
  endtask

  // count_t wraps the same way the hardware does
  task automatic bump(input int idx);
    expected[idx] = expected[idx] + 1'b1;
  endtask

  task automatic model_access(input logic [`CACHE_ADDR_W-1:0] a, input op_e o,
                              input repl_e repl, input wpol_e wpol);
    logic [`CACHE_ADDR_W-1:0] blk;
    int set [2];
    logic [`CACHE_ADDR_W-1:0] tag [2];
    int p1;
    int p2;
    blk = a >> `CACHE_BLOCK_BITS;
    for (int l = 0; l < 2; l++) begin
      set[l] = int'(blk & ((1 << set_bits_of(l)) - 1));
      tag[l] = blk >> set_bits_of(l);
    end
    p1 = find_way(0, set[0], tag[0]);
    if (o == OP_READ) begin
      bump(0);
    end else begin
      bump(3);
    end
    if (p1 >= 0) begin
      bump(1);
      // Only LRU reorders on a hit
      if (repl == REPL_LRU) begin
        move_to_front(0, set[0], p1, tag[0]);
      end
    end else begin
      bump(2);
      bump(4);
      move_to_front(0, set[0], ways_of(0) - 1, tag[0]);
      p2 = find_way(1, set[1], tag[1]);
      if (p2 >= 0) begin
        bump(5);
        if (repl == REPL_LRU) begin
          move_to_front(1, set[1], p2, tag[1]);
        end
      end else begin
        bump(6);
        move_to_front(1, set[1], ways_of(1) - 1, tag[1]);
      end
    end
    // Write-back forwards a write only on an L1 miss
    if ((o == OP_WRITE) && ((wpol == WP_THROUGH) || (p1 < 0))) begin
      bump(7);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Comparison
  //////////////////////////////////////////////////////////////////////

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("FAILED t=%0t %s expected %0b got %0b", $time, name, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic compare_counters();
    for (int i = 0; i < N_CNT; i++) begin
      if (actual[i] !== expected[i]) begin
        $display("FAILED t=%0t %s expected %0d got %0d", $time, cnt_name[i],
                 expected[i], actual[i]);
        errors++;
      end
    end
  endtask

  initial begin
    int n;
    int cycles;
    errors  = 0;
    checked = 0;
    for (int l = 0; l < 2; l++) begin
      for (int s = 0; s < MAX_SETS; s++) begin
        for (int w = 0; w < MAX_WAYS; w++) begin
          m_valid[l][s][w] = 1'b0;
          m_tag[l][s][w]   = '0;
        end
      end
    end
    for (int i = 0; i < N_CNT; i++) begin
      expected[i] = '0;
    end

    // Idle state right after reset
    n = 0;
    @(posedge clk);
    while (reset && (n < RESET_TIMEOUT)) begin
      @(posedge clk);
      n++;
    end
    if (reset) begin
      $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
      errors++;
    end else begin
      check_bit("busy", 1'b0, busy);
      check_bit("done", 1'b0, done);
      compare_counters();
    end

    forever begin
      @(posedge clk);
      if (!reset && start && !busy) begin
        model_access(addr, op, replace_policy, write_policy);
        @(posedge clk);
        cycles = 1;
        // busy must hold until done shows up
        while (!done && (cycles < DONE_TIMEOUT)) begin
          check_bit("busy", 1'b1, busy);
          @(posedge clk);
          cycles++;
        end
        if (!done) begin
          $display("No done within %0d cycles of the start at t=%0t", DONE_TIMEOUT, $time);
          errors++;
        end else begin
          if (cycles != DONE_LATENCY) begin
            $display("FAILED t=%0t done latency expected %0d got %0d", $time,
                     DONE_LATENCY, cycles);
            errors++;
          end
          check_bit("busy", 1'b1, busy);
          compare_counters();
          @(posedge clk);
          // Single-cycle done, then back to idle
          check_bit("done", 1'b0, done);
          check_bit("busy", 1'b0, busy);
        end
        checked++;
      end
    end
  end

endmodule

//--- tb_cache_sim.sv
`timescale 1ns/100ps
`include "cache_sim_settings.svh"

module tb_cache_sim
  import cache_sim_pkg::*;
();

  localparam int N_ACCESS      = 400;
  localparam int POLICY_PERIOD = 100;
  localparam int IDLE_TIMEOUT  = 50;
  localparam int CHECK_TIMEOUT = 50;
  localparam int BLK_W         = `CACHE_ADDR_W - `CACHE_BLOCK_BITS;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic clk;
  logic reset;
  logic start;
  logic [`CACHE_ADDR_W-1:0] addr;
  op_e op;
  repl_e replace_policy;
  wpol_e write_policy;
  logic busy;
  logic done;
  count_t l1_reads;
  count_t l1_hits;
  count_t l1_misses;
  count_t l1_writes;
  count_t l2_reads;
  count_t l2_hits;
  count_t l2_misses;
  count_t l2_writes;

  int errors;
  int checked;
  int issued;
  logic timed_out;
  logic [31:0] lfsr = 32'hfd82_fc97;

  cache_sim_top i_cache_sim_top (.*);

  cache_checker i_cache_checker (.*);

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Random source and stimulus
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit
  function automatic logic lfsr_step();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ LFSR_TAPS;
    end
    return b;
  endfunction

  function automatic logic [63:0] random_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_step()};
    end
    return v;
  endfunction

  // Wait for an idle DUT, bounded
  task automatic wait_idle();
    int n;
    n = 0;
    @(posedge clk);
    while (busy && (n < IDLE_TIMEOUT)) begin
      @(posedge clk);
      n++;
    end
    if (busy) begin
      $display("DUT still busy after %0d cycles", IDLE_TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  // Small pool stays in L1, large pool exercises L2 hits and misses
  task automatic drive_access(input int idx);
    logic [BLK_W-1:0] blk;
    logic [`CACHE_BLOCK_BITS-1:0] offset;
    if (lfsr_step()) begin
      blk = BLK_W'(random_bits(4));
    end else begin
      blk = BLK_W'(random_bits(10));
    end
    offset = `CACHE_BLOCK_BITS'(random_bits(`CACHE_BLOCK_BITS));
    start <= 1'b1;
    addr  <= {blk, offset};
    op    <= lfsr_step() ? OP_WRITE : OP_READ;
    // Four policy combinations, one per block of accesses
    replace_policy <= ((idx / POLICY_PERIOD) % 2 == 1) ? REPL_LRU : REPL_FIFO;
    write_policy   <= ((idx / (2 * POLICY_PERIOD)) % 2 == 1) ? WP_BACK : WP_THROUGH;
    @(posedge clk);
    start <= 1'b0;
  endtask

  // Let the checker finish the last access
  task automatic wait_checked();
    int n;
    n = 0;
    while ((checked < issued) && (n < CHECK_TIMEOUT)) begin
      @(posedge clk);
      n++;
    end
    if (checked < issued) begin
      $display("Checker saw %0d of %0d accesses complete", checked, issued);
      timed_out = 1'b1;
    end
  endtask

  initial begin
    reset          = 1'b1;
    start          = 1'b0;
    addr           = '0;
    op             = OP_READ;
    replace_policy = REPL_FIFO;
    write_policy   = WP_THROUGH;
    timed_out      = 1'b0;
    issued         = 0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    for (int i = 0; (i < N_ACCESS) && !timed_out; i++) begin
      wait_idle();
      if (!timed_out) begin
        drive_access(i);
        issued++;
      end
    end
    wait_checked();

    $display("Accesses issued %0d, checked %0d, errors %0d", issued, checked, errors);
    if ((errors == 0) && !timed_out && (checked == issued)) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+.
cache_sim_pkg.sv
tag_store.sv
stat_counters.sv
cache_ctrl.sv
cache_sim_top.sv
cache_checker.sv
tb_cache_sim.sv
